// ==== design/machine_pkg.sv ====
`default_nettype none

package machine_pkg;

   // byte address into the 8 KiB data space
   parameter int ADDR_W = 13;
   parameter int DATA_W = 32;
   parameter int MASK_W = 4;   // byte lanes per word

   // lane convention, shared by the RAM, the load/store unit and the model:
   //   byte lane k lives in data bits 8k+7 down to 8k
   //   lane k is enabled by wr_mask bit 3-k, so mask bit 3 is the low byte
   //   e.g. sb to offset 0 -> 4'b1000, sh to offset 2 -> 4'b0011

   // RV32 load/store operations
   typedef enum logic [2:0] {
      op_lb,
      op_lh,
      op_lw,
      op_lbu,
      op_lhu,
      op_sb,
      op_sh,
      op_sw
   } mem_op_t;

endpackage

`default_nettype wire

// ==== design/mem_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one word-access port, single-cycle request strobes
interface mem_bus_if;

   logic                           rd_en;
   logic                           wr_en;
   logic [machine_pkg::ADDR_W-1:0] addr;
   logic [machine_pkg::DATA_W-1:0] wr_data;
   logic [machine_pkg::MASK_W-1:0] wr_mask;
   logic [machine_pkg::DATA_W-1:0] rd_data;   // only meaningful with rd_valid
   logic                           rd_valid;  // one cycle after rd_en

   modport requester (
      output rd_en,
      output wr_en,
      output addr,
      output wr_data,
      output wr_mask,
      input  rd_data,
      input  rd_valid
   );

   modport memory (
      input  rd_en,
      input  wr_en,
      input  addr,
      input  wr_data,
      input  wr_mask,
      output rd_data,
      output rd_valid
   );

endinterface

`default_nettype wire

// ==== design/bram.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram #(
   parameter int MEM_WORDS = 2048
) (
   input  logic      clk,
   input  logic      reset,
   mem_bus_if.memory bus
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [machine_pkg::DATA_W-1:0] mem [MEM_WORDS];
   logic [IDX_W-1:0]               word_idx;

   // byte address to word line, wrapping at the array size
   assign word_idx = IDX_W'((bus.addr >> 2) % MEM_WORDS);

   always_ff @(posedge clk) begin
      if (bus.wr_en) begin
         for (int k = 0; k < machine_pkg::MASK_W; k++) begin
            // mask bit 3 is lane 0
            if (bus.wr_mask[machine_pkg::MASK_W-1-k]) begin
               mem[word_idx][8*k +: 8] <= bus.wr_data[8*k +: 8];
            end
         end
      end
      if (bus.rd_en) begin
         bus.rd_data <= mem[word_idx];   // old contents on a same-edge write
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         bus.rd_valid <= 1'b0;
      end else begin
         bus.rd_valid <= bus.rd_en;
      end
   end

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           fetch_en,
   input  logic [machine_pkg::ADDR_W-1:0] fetch_addr,
   output logic [machine_pkg::DATA_W-1:0] fetch_data,
   output logic                           fetch_valid,
   output logic                           fetch_stall,
   mem_bus_if.memory                      lsu_bus,
   mem_bus_if.requester                   ram_bus
);

   logic lsu_req;
   logic fetch_go;
   logic owner_lsu;   // who issued the read now returning

   assign lsu_req  = lsu_bus.rd_en | lsu_bus.wr_en;
   assign fetch_go = fetch_en & ~lsu_req;

   // load/store always wins, a colliding fetch is dropped
   assign fetch_stall = fetch_en & lsu_req;

   assign ram_bus.rd_en   = lsu_bus.rd_en | fetch_go;
   assign ram_bus.wr_en   = lsu_bus.wr_en;
   assign ram_bus.wr_data = lsu_bus.wr_data;
   assign ram_bus.wr_mask = lsu_bus.wr_mask;

   always_comb begin
      if (lsu_req) begin
         ram_bus.addr = lsu_bus.addr;
      end else begin
         ram_bus.addr = {fetch_addr[machine_pkg::ADDR_W-1:2], 2'b00};   // fetch is word only
      end
   end

   // one bit is enough, reads return in the next cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         owner_lsu <= 1'b0;
      end else if (ram_bus.rd_en) begin
         owner_lsu <= lsu_bus.rd_en;
      end
   end

   // data goes to both sides, only the strobe is steered
   assign fetch_data       = ram_bus.rd_data;
   assign lsu_bus.rd_data  = ram_bus.rd_data;
   assign fetch_valid      = ram_bus.rd_valid & ~owner_lsu;
   assign lsu_bus.rd_valid = ram_bus.rd_valid & owner_lsu;

endmodule

`default_nettype wire

// ==== design/lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           mem_en,
   input  machine_pkg::mem_op_t           mem_op,
   input  logic [machine_pkg::ADDR_W-1:0] mem_addr,
   input  logic [machine_pkg::DATA_W-1:0] mem_wdata,
   output logic [machine_pkg::DATA_W-1:0] load_data,
   output logic                           load_valid,
   output logic                           misaligned,
   mem_bus_if.requester                   bus
);

   logic [1:0]           offset;
   logic                 is_load;
   logic                 is_half;
   logic                 is_word;
   logic                 bad_align;
   machine_pkg::mem_op_t op_q;
   logic [1:0]           off_q;
   logic [7:0]           lane_b;
   logic [15:0]          lane_h;

   assign offset = mem_addr[1:0];

   // decode direction and access size
   always_comb begin
      is_load = 1'b1;
      is_half = 1'b0;
      is_word = 1'b0;
      case (mem_op)
         machine_pkg::op_lh, machine_pkg::op_lhu: is_half = 1'b1;
         machine_pkg::op_lw: is_word = 1'b1;
         machine_pkg::op_sb: is_load = 1'b0;
         machine_pkg::op_sh: begin
            is_load = 1'b0;
            is_half = 1'b1;
         end
         machine_pkg::op_sw: begin
            is_load = 1'b0;
            is_word = 1'b1;
         end
         default: ;   // lb, lbu
      endcase
   end

   assign bad_align = (is_half & offset[0]) | (is_word & (offset != 2'b00));

   // misaligned accesses never reach the RAM
   assign bus.rd_en = mem_en & is_load & ~bad_align;
   assign bus.wr_en = mem_en & ~is_load & ~bad_align;
   assign bus.addr  = mem_addr;

   // replicate store data so every lane holds it, the mask picks the lanes
   always_comb begin
      if (is_word) begin
         bus.wr_data = mem_wdata;
         bus.wr_mask = 4'b1111;
      end else if (is_half) begin
         bus.wr_data = {2{mem_wdata[15:0]}};
         bus.wr_mask = 4'b1100 >> offset;
      end else begin
         bus.wr_data = {machine_pkg::MASK_W{mem_wdata[7:0]}};
         bus.wr_mask = 4'b1000 >> offset;
      end
   end

   // remember how to unpack the returning word
   always_ff @(posedge clk) begin
      if (bus.rd_en) begin
         op_q  <= mem_op;
         off_q <= offset;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         misaligned <= 1'b0;
      end else begin
         misaligned <= mem_en & bad_align;
      end
   end

   assign lane_b = bus.rd_data[8*off_q +: 8];
   assign lane_h = bus.rd_data[16*off_q[1] +: 16];

   always_comb begin
      case (op_q)
         machine_pkg::op_lb:  load_data = {{(machine_pkg::DATA_W-8){lane_b[7]}}, lane_b};
         machine_pkg::op_lbu: load_data = {{(machine_pkg::DATA_W-8){1'b0}}, lane_b};
         machine_pkg::op_lh:  load_data = {{(machine_pkg::DATA_W-16){lane_h[15]}}, lane_h};
         machine_pkg::op_lhu: load_data = {{(machine_pkg::DATA_W-16){1'b0}}, lane_h};
         default:             load_data = bus.rd_data;
      endcase
   end

   // the arbiter never delays us, so the return strobe is the load strobe
   assign load_valid = bus.rd_valid;

endmodule

`default_nettype wire

// ==== design/machine_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module machine_mem #(
   parameter int MEM_WORDS = 2048
) (
   input  logic                           clk,
   input  logic                           reset,
   // instruction fetch
   input  logic                           fetch_en,
   input  logic [machine_pkg::ADDR_W-1:0] fetch_addr,
   output logic [machine_pkg::DATA_W-1:0] fetch_data,
   output logic                           fetch_valid,
   output logic                           fetch_stall,
   // load/store
   input  logic                           mem_en,
   input  machine_pkg::mem_op_t           mem_op,
   input  logic [machine_pkg::ADDR_W-1:0] mem_addr,
   input  logic [machine_pkg::DATA_W-1:0] mem_wdata,
   output logic [machine_pkg::DATA_W-1:0] load_data,
   output logic                           load_valid,
   output logic                           misaligned
);

   mem_bus_if lsu_bus ();
   mem_bus_if ram_bus ();

   lsu lsu_i (
      .clk        (clk),
      .reset      (reset),
      .mem_en     (mem_en),
      .mem_op     (mem_op),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .load_data  (load_data),
      .load_valid (load_valid),
      .misaligned (misaligned),
      .bus        (lsu_bus.requester)
   );

   mem_arbiter arb_i (
      .clk         (clk),
      .reset       (reset),
      .fetch_en    (fetch_en),
      .fetch_addr  (fetch_addr),
      .fetch_data  (fetch_data),
      .fetch_valid (fetch_valid),
      .fetch_stall (fetch_stall),
      .lsu_bus     (lsu_bus.memory),
      .ram_bus     (ram_bus.requester)
   );

   bram #(
      .MEM_WORDS (MEM_WORDS)
   ) ram_i (
      .clk   (clk),
      .reset (reset),
      .bus   (ram_bus.memory)
   );

endmodule

`default_nettype wire

// ==== testbench/machine_mem_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module machine_mem_checker #(
   parameter int MEM_WORDS = 2048
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           fetch_en,
   input  logic [machine_pkg::ADDR_W-1:0] fetch_addr,
   input  logic [machine_pkg::DATA_W-1:0] fetch_data,
   input  logic                           fetch_valid,
   input  logic                           fetch_stall,
   input  logic                           mem_en,
   input  machine_pkg::mem_op_t           mem_op,
   input  logic [machine_pkg::ADDR_W-1:0] mem_addr,
   input  logic [machine_pkg::DATA_W-1:0] mem_wdata,
   input  logic [machine_pkg::DATA_W-1:0] load_data,
   input  logic                           load_valid,
   input  logic                           misaligned,
   input  logic [machine_pkg::DATA_W-1:0] exp_data,    // expected value from the stim file
   input  logic                           exp_check,
   input  logic                           exp_mis,
   output int                             checks,
   output int                             errors
);

   logic [31:0] model [MEM_WORDS];   // byte-lane reference memory
   // sampled at the last edge, answered right after it
   logic        due_load;
   logic        due_fetch;
   logic        due_mis;
   logic        due_stim;
   logic        due_expmis;
   logic [31:0] due_data;
   logic [31:0] due_exp;

   function automatic int size_of(input machine_pkg::mem_op_t op);
      case (op)
         machine_pkg::op_lb, machine_pkg::op_lbu, machine_pkg::op_sb: return 1;
         machine_pkg::op_lh, machine_pkg::op_lhu, machine_pkg::op_sh: return 2;
         default: return 4;
      endcase
   endfunction

   function automatic int word_index(input logic [machine_pkg::ADDR_W-1:0] addr);
      return (int'(addr) / 4) % MEM_WORDS;
   endfunction

   // pick the addressed bytes and extend them as RV32 asks
   function automatic logic [31:0] extract(input machine_pkg::mem_op_t op,
                                           input logic [31:0] word, input logic [1:0] off);
      logic [31:0] s;
      s = word >> (8 * off);
      case (op)
         machine_pkg::op_lb:  return {{24{s[7]}}, s[7:0]};
         machine_pkg::op_lbu: return {24'h0, s[7:0]};
         machine_pkg::op_lh:  return {{16{s[15]}}, s[15:0]};
         machine_pkg::op_lhu: return {16'h0, s[15:0]};
         default:             return word;
      endcase
   endfunction

   task automatic report_fail(input string msg);
      errors++;
      $display("[FAIL] %0t %s", $time, msg);
   endtask

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
      checks++;
      if (got !== want) begin
         report_fail($sformatf("%s got %h expected %h", what, got, want));
      end
   endtask

   initial begin
      checks = 0;
      errors = 0;
   end

   always @(posedge clk) begin
      logic ok;
      logic store;
      logic req;
      int   idx;
      if (reset) begin
         {due_load, due_fetch, due_mis, due_stim} = '0;
      end else begin
         ok    = (int'(mem_addr) % size_of(mem_op)) == 0;
         store = mem_op >= machine_pkg::op_sb;
         req   = mem_en && ok;
         if (fetch_stall !== (fetch_en && req)) begin
            report_fail($sformatf("fetch_stall is %b", fetch_stall));
         end
         due_load   = req && !store;
         due_mis    = mem_en && !ok;
         due_fetch  = fetch_en && !req;
         due_stim   = exp_check;
         due_exp    = exp_data;
         due_expmis = exp_mis;
         if (due_load) begin
            due_data = extract(mem_op, model[word_index(mem_addr)], mem_addr[1:0]);
         end else if (due_fetch) begin
            due_data = model[word_index(fetch_addr)];
         end
         if (req && store) begin
            idx = word_index(mem_addr);
            for (int b = 0; b < size_of(mem_op); b++) begin
               model[idx][8*(int'(mem_addr[1:0])+b) +: 8] = mem_wdata[8*b +: 8];
            end
         end
      end
   end

   // outputs settled half a cycle after the edge
   always @(negedge clk) begin
      if (!reset) begin
         if (load_valid !== due_load) report_fail($sformatf("load_valid is %b", load_valid));
         if (fetch_valid !== due_fetch) report_fail($sformatf("fetch_valid is %b", fetch_valid));
         if (misaligned !== due_mis) report_fail($sformatf("misaligned is %b", misaligned));
         if (due_load) begin
            compare("load_data vs model", load_data, due_data);
            if (due_stim) compare("load_data vs stim", load_data, due_exp);
         end
         if (due_fetch) begin
            compare("fetch_data vs model", fetch_data, due_data);
            if (due_stim) compare("fetch_data vs stim", fetch_data, due_exp);
         end
         if (due_stim) compare("misaligned vs stim", 32'(misaligned), 32'(due_expmis));
      end
   end

endmodule

`default_nettype wire

// ==== testbench/machine_mem_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module machine_mem_assert (
   input logic clk,
   input logic reset,
   input logic ram_rd_en,
   input logic ram_wr_en,
   input logic ram_rd_valid,
   input logic lsu_rd_en,
   input logic fetch_valid,
   input logic lsu_rd_valid
);

   one_access_per_cycle: assert property (@(posedge clk) disable iff (reset)
      !(ram_rd_en && ram_wr_en))
      else $error("ram read and write requested in the same cycle");

   // each return goes to the side that issued the read, and only there
   read_returns_to_owner: assert property (@(posedge clk) disable iff (reset)
      ram_rd_en |=> (lsu_rd_valid == $past(lsu_rd_en)) && (fetch_valid != $past(lsu_rd_en)))
      else $error("read return steered to the wrong requester");

   read_returns_next_cycle: assert property (@(posedge clk) disable iff (reset)
      ram_rd_en |=> ram_rd_valid)
      else $error("ram read not answered one cycle later");

endmodule

bind mem_arbiter machine_mem_assert assert_i (
   .clk          (clk),
   .reset        (reset),
   .ram_rd_en    (ram_bus.rd_en),
   .ram_wr_en    (ram_bus.wr_en),
   .ram_rd_valid (ram_bus.rd_valid),
   .lsu_rd_en    (lsu_bus.rd_en),
   .fetch_valid  (fetch_valid),
   .lsu_rd_valid (lsu_bus.rd_valid)
);

`default_nettype wire

// ==== testbench/machine_mem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module machine_mem_tb;

   localparam int MEM_WORDS = 2048;
   localparam int WAIT_MAX  = 20;

   logic                           clk;
   logic                           reset;
   logic                           fetch_en;
   logic [machine_pkg::ADDR_W-1:0] fetch_addr;
   logic [machine_pkg::DATA_W-1:0] fetch_data;
   logic                           fetch_valid;
   logic                           fetch_stall;
   logic                           mem_en;
   machine_pkg::mem_op_t           mem_op;
   logic [machine_pkg::ADDR_W-1:0] mem_addr;
   logic [machine_pkg::DATA_W-1:0] mem_wdata;
   logic [machine_pkg::DATA_W-1:0] load_data;
   logic                           load_valid;
   logic                           misaligned;
   logic [31:0]                    exp_data;
   logic                           exp_check;
   logic                           exp_mis;
   int                             checks;
   int                             errors;
   int                             timeouts;
   int                             seed;
   int                             cur_test;
   int                             tests_run;
   int                             checks0, errors0, timeouts0;
   bit                             file_ok;

   machine_mem #(.MEM_WORDS(MEM_WORDS)) dut_i (.*);

   machine_mem_checker #(.MEM_WORDS(MEM_WORDS)) check_i (.*);

   always #50 clk = ~clk;

   task automatic idle_inputs;
      fetch_en  = 1'b0;
      fetch_addr = '0;
      mem_en    = 1'b0;
      mem_op    = machine_pkg::op_lb;
      mem_addr  = '0;
      mem_wdata = '0;
      exp_data  = '0;
      exp_check = 1'b0;
      exp_mis   = 1'b0;
   endtask

   // 0 fetch_valid, 1 load_valid, 2 misaligned
   task automatic wait_response(input int which);
      bit seen;
      seen = 0;
      for (int n = 0; n < WAIT_MAX && !seen; n++) begin
         @(negedge clk);
         seen = (which == 0) ? fetch_valid : (which == 1) ? load_valid : misaligned;
      end
      if (!seen) begin
         timeouts++;
         $display("timeout in test %0d: %s never arrived", cur_test,
                  (which == 0) ? "fetch_valid" : (which == 1) ? "load_valid" : "misaligned");
      end
   endtask

   task automatic finish_test;
      string verdict;
      @(posedge clk);   // after the checker's falling-edge compares
      verdict = (errors == errors0 && timeouts == timeouts0) ? "ok" : "FAILED";
      $display("test %0d: %0d checks, %0d errors, %s", cur_test, checks - checks0,
               errors - errors0 + timeouts - timeouts0, verdict);
      tests_run++;
      checks0   = checks;
      errors0   = errors;
      timeouts0 = timeouts;
      @(negedge clk);   // back to the drive edge
   endtask

   task automatic random_sweep(input int count);
      logic [machine_pkg::ADDR_W-1:0] a;
      for (int i = 0; i < count; i++) begin
         a = machine_pkg::ADDR_W'($random(seed)) & 13'h1ffc;   // word aligned
         mem_en = 1'b1;
         mem_op = machine_pkg::op_sw;
         mem_addr = a;
         mem_wdata = $random(seed);
         @(negedge clk);
         mem_op = machine_pkg::op_lw;
         wait_response(1);
         idle_inputs();
      end
   endtask

   task automatic run_line(input int kind, input int op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] expv, input int mis);
      mem_op    = machine_pkg::mem_op_t'(op[2:0]);
      mem_addr  = addr[machine_pkg::ADDR_W-1:0];
      mem_wdata = wdata;
      exp_data  = expv;
      exp_mis   = mis[0];
      exp_check = 1'b1;
      case (kind)
         0: begin
            fetch_en   = 1'b1;
            fetch_addr = addr[machine_pkg::ADDR_W-1:0];
            wait_response(0);
         end
         1: begin
            mem_en = 1'b1;
            if (mis != 0) wait_response(2);
            else if (op < 5) wait_response(1);
            else @(negedge clk);
         end
         2: begin
            mem_en = 1'b1;
            fetch_en = 1'b1;
            fetch_addr = wdata[machine_pkg::ADDR_W-1:0];   // fetch collides with the load
            wait_response(1);
         end
         3: begin
            mem_en = 1'b1;   // back to back, the next line follows at once
            @(negedge clk);
            return;
         end
         default: begin
            exp_check = 1'b0;
            random_sweep(int'(wdata));
         end
      endcase
      idle_inputs();
   endtask

   initial begin
      int          fd;
      int          n;
      int          test, kind, op, mis;
      logic [31:0] addr, wdata, expv;
      string       line;
      clk = 1'b0;
      reset = 1'b1;
      seed = 66435;
      {checks0, errors0, timeouts0, timeouts, tests_run, cur_test} = '0;
      idle_inputs();
      repeat (5) @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);   // outputs must stay quiet
      fd = $fopen("testbench/machine_mem_stim.txt", "r");
      file_ok = fd != 0;
      if (!file_ok) $display("could not open the stim file");
      while (file_ok && !$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%h %h %h %h %h %h %h", test, kind, op, addr, wdata, expv, mis);
         if (n == 7) begin
            if (test != cur_test && cur_test != 0) finish_test();
            cur_test = test;
            run_line(kind, op, addr, wdata, expv, mis);
         end
      end
      if (file_ok) $fclose(fd);
      idle_inputs();
      repeat (2) @(negedge clk);
      if (cur_test != 0) finish_test();
      $display("tests %0d, checks %0d, errors %0d, timeouts %0d",
               tests_run, checks, errors, timeouts);
      if (file_ok && tests_run > 0 && errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== machine_mem.f ====
design/machine_pkg.sv
design/mem_bus_if.sv
design/bram.sv
design/mem_arbiter.sv
design/lsu.sv
design/machine_mem.sv
testbench/machine_mem_checker.sv
testbench/machine_mem_assert.sv
testbench/machine_mem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = machine_mem_tb
FILELIST  = machine_mem.f
PASS_MSG  = Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== testbench/machine_mem_stim.txt ====
# test kind op addr wdata expect misaligned, all hex
# kind 0 fetch, 1 load/store, 2 load with colliding fetch (wdata = fetch addr),
# 3 back-to-back load, 4 random sweep (wdata = count); op 0..7 = lb lh lw lbu lhu sb sh sw
1 1 7 0100 12345678 00000000 0
1 1 2 0100 00000000 12345678 0
1 0 0 0100 00000000 12345678 0
1 0 0 0102 00000000 12345678 0
2 1 7 0200 00000000 00000000 0
2 1 5 0200 00000080 00000000 0
2 1 5 0203 0000007f 00000000 0
2 1 5 0201 000000a5 00000000 0
2 1 5 0202 0000003c 00000000 0
2 1 6 0204 00008001 00000000 0
2 1 6 0206 00001234 00000000 0
2 1 0 0200 00000000 ffffff80 0
2 1 3 0200 00000000 00000080 0
2 1 0 0203 00000000 0000007f 0
2 1 0 0201 00000000 ffffffa5 0
2 1 3 0202 00000000 0000003c 0
2 1 2 0200 00000000 7f3ca580 0
2 1 1 0204 00000000 ffff8001 0
2 1 4 0204 00000000 00008001 0
2 1 1 0206 00000000 00001234 0
2 1 2 0204 00000000 12348001 0
3 1 1 0205 00000000 00000000 1
3 1 2 0206 00000000 00000000 1
3 1 6 0207 0000ffff 00000000 1
3 1 2 0204 00000000 12348001 0
4 2 2 0100 00000204 12345678 0
4 0 0 0204 00000000 12348001 0
5 3 2 0100 00000000 12345678 0
5 3 2 0200 00000000 7f3ca580 0
5 3 3 0204 00000000 00000001 0
5 1 4 0206 00000000 00001234 0
6 4 0 0000 00000040 00000000 0
